//--- sim.f
src/snake_geom_pkg.sv
src/snake_ctrl_pkg.sv
src/move_sequencer.sv
src/head_stepper.sv
src/body_shifter.sv
src/snake_body_ctrl.sv
testbench/snake_checker.sv
testbench/tb_snake_body_ctrl.sv

//--- Bender.yml
package:
  name: snake_body_ctrl

sources:
  - src/snake_geom_pkg.sv
  - src/snake_ctrl_pkg.sv
  - src/move_sequencer.sv
  - src/head_stepper.sv
  - src/body_shifter.sv
  - src/snake_body_ctrl.sv
  - target: test
    files:
      - testbench/snake_checker.sv
      - testbench/tb_snake_body_ctrl.sv

//--- testbench/tb_snake_body_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_snake_body_ctrl;

  import snake_geom_pkg::*;

  // small body so the score saturates at 6
  localparam int MAX_LENGTH   = 8;
  localparam int SEED         = 35;
  // edges to wait for a tick to be seen
  localparam int TICK_TIMEOUT = 50;

  logic                  main_clk;
  logic                  nrst;
  logic                  run;
  logic                  body_tick;
  logic                  enable;
  logic                  apple_hit;
  logic                  wall_hit;
  dir_e                  dir;
  pos_t                  head;
  pos_t [MAX_LENGTH-1:0] body;
  logic [SCORE_W-1:0]    score;
  int                    test_id;
  int                    ticks_seen;
  int                    checks;
  int                    errors;
  int unsigned           seed_out;

  initial begin
    main_clk = 1'b0;
    forever #5 main_clk = ~main_clk;
  end

  snake_body_ctrl #(
    .MAX_LENGTH (MAX_LENGTH)
  ) snake_body_ctrl_i (
    .main_clk  (main_clk),
    .nrst      (nrst),
    .run       (run),
    .body_tick (body_tick),
    .enable    (enable),
    .apple_hit (apple_hit),
    .wall_hit  (wall_hit),
    .dir       (dir),
    .head      (head),
    .body      (body),
    .score     (score)
  );

  snake_checker #(
    .MAX_LENGTH (MAX_LENGTH)
  ) checker_i (
    .main_clk   (main_clk),
    .nrst       (nrst),
    .run        (run),
    .body_tick  (body_tick),
    .enable     (enable),
    .apple_hit  (apple_hit),
    .wall_hit   (wall_hit),
    .dir        (dir),
    .head       (head),
    .body       (body),
    .score      (score),
    .test_id    (test_id),
    .ticks_seen (ticks_seen),
    .checks     (checks),
    .errors     (errors)
  );

  function automatic dir_e random_dir();
    logic [1:0] r;
    r = 2'($urandom % 4);
    return dir_e'(r);
  endfunction

  // wait until the checker has seen the tick count reach target
  task automatic wait_ticks(input int target);
    int waited;
    waited = 0;
    while (ticks_seen < target && waited < TICK_TIMEOUT) begin
      @(negedge main_clk);
      waited++;
    end
    if (ticks_seen < target) begin
      $display("timeout in test %0d, waited for %0d body ticks but saw %0d",
               test_id, target, ticks_seen);
      $display("Something failed");
      $finish;
    end
  endtask

  // n single-cycle ticks with random gaps, collisions only on tick cycles
  task automatic send_ticks(input int n, input logic apple, input logic wall,
                            input logic rand_dir, input dir_e fixed_dir);
    int target;
    int gap;
    int k;
    target = ticks_seen + n;
    for (k = 0; k < n; k++) begin
      @(negedge main_clk);
      body_tick = 1'b1;
      apple_hit = apple;
      wall_hit  = wall;
      dir       = rand_dir ? random_dir() : fixed_dir;
      @(negedge main_clk);
      body_tick = 1'b0;
      apple_hit = 1'b0;
      wall_hit  = 1'b0;
      gap       = $urandom % 3;
      repeat (gap) @(negedge main_clk);
    end
    wait_ticks(target);
  endtask

  initial begin
    nrst      = 1'b0;
    run       = 1'b0;
    body_tick = 1'b0;
    enable    = 1'b0;
    apple_hit = 1'b0;
    wall_hit  = 1'b0;
    dir       = dir_up;
    test_id   = 0;
    seed_out  = $urandom(SEED);
    repeat (8) @(negedge main_clk);
    nrst = 1'b1;
    // start pose holds with no tick
    repeat (4) @(negedge main_clk);

    // long run to the right wraps x, then random steps
    test_id = 1;
    run     = 1'b1;
    enable  = 1'b1;
    send_ticks(20, 1'b0, 1'b0, 1'b0, dir_right);
    send_ticks(30, 1'b0, 1'b0, 1'b1, dir_up);

    // nine apples, the last three past saturation
    test_id = 2;
    send_ticks(9, 1'b1, 1'b0, 1'b0, dir_down);
    send_ticks(12, 1'b0, 1'b0, 1'b1, dir_up);

    test_id = 3;
    send_ticks(1, 1'b0, 1'b1, 1'b0, dir_up);
    send_ticks(5, 1'b0, 1'b0, 1'b1, dir_up);
    // restart must win over a low enable
    enable = 1'b0;
    send_ticks(1, 1'b0, 1'b1, 1'b0, dir_left);
    enable = 1'b1;
    send_ticks(4, 1'b0, 1'b0, 1'b1, dir_up);

    // paused, idle and disabled all hold
    test_id = 4;
    run = 1'b0;
    send_ticks(4, 1'b0, 1'b0, 1'b1, dir_up);
    send_ticks(2, 1'b1, 1'b0, 1'b1, dir_up);
    send_ticks(2, 1'b0, 1'b1, 1'b1, dir_up);
    run = 1'b1;
    repeat (6) @(negedge main_clk);
    enable = 1'b0;
    send_ticks(4, 1'b0, 1'b0, 1'b1, dir_up);
    send_ticks(2, 1'b1, 1'b0, 1'b1, dir_up);
    enable = 1'b1;

    @(negedge main_clk);
    test_id = 5;
    @(negedge main_clk);
    $display("total checks %0d, errors %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/snake_checker.sv
`timescale 1ns/10ps
`default_nettype none

module snake_checker #(
  parameter int MAX_LENGTH = 8
) (
  input  logic                                  main_clk,
  input  logic                                  nrst,
  input  logic                                  run,
  input  logic                                  body_tick,
  input  logic                                  enable,
  input  logic                                  apple_hit,
  input  logic                                  wall_hit,
  input  snake_geom_pkg::dir_e                  dir,
  input  snake_geom_pkg::pos_t                  head,
  input  snake_geom_pkg::pos_t [MAX_LENGTH-1:0] body,
  input  logic [snake_geom_pkg::SCORE_W-1:0]    score,
  input  int                                    test_id,
  output int                                    ticks_seen,
  output int                                    checks,
  output int                                    errors
);

  import snake_geom_pkg::*;

  // widest compared field is the whole body
  localparam int WIDE = MAX_LENGTH * 8;

  // inputs seen at one rising edge
  typedef struct packed {
    logic run;
    logic tick;
    logic enable;
    logic apple;
    logic wall;
    dir_e dir;
  } ctrl_in_t;

  // expected outputs after an edge
  typedef struct packed {
    pos_t                  head;
    pos_t [MAX_LENGTH-1:0] body;
    logic [SCORE_W-1:0]    score;
  } snake_state_t;

  snake_state_t model;
  ctrl_in_t     sampled;
  int           cur_id;
  int           test_checks;
  int           test_errors;

  function automatic string test_name(int id);
    case (id)
      0:       return "reset_state";
      1:       return "plain_moves";
      2:       return "apples";
      3:       return "wall_hit";
      4:       return "no_change";
      default: return "done";
    endcase
  endfunction

  // one cell in direction d, board is 16 wide so -1 is +15
  function automatic pos_t advance_cell(pos_t p, dir_e d);
    pos_t q;
    q = p;
    case (d)
      dir_up:    q.y = coord_t'((int'(p.y) + 15) % 16);
      dir_down:  q.y = coord_t'((int'(p.y) + 1) % 16);
      dir_right: q.x = coord_t'((int'(p.x) + 1) % 16);
      default:   q.x = coord_t'((int'(p.x) + 15) % 16);
    endcase
    return q;
  endfunction

  function automatic snake_state_t start_state();
    snake_state_t s;
    s         = '0;
    s.head    = START_HEAD;
    s.body[0] = START_HEAD;
    s.body[1] = START_TAIL;
    return s;
  endfunction

  // reference model of one edge
  function automatic snake_state_t predict_next(snake_state_t s, ctrl_in_t c);
    snake_state_t n;
    pos_t         nh;
    int           i;
    n = s;
    if (!(c.run && c.tick)) begin
      return n;
    end
    if (c.wall) begin
      // restart keeps the score
      n       = start_state();
      n.score = s.score;
    end else if (c.enable) begin
      nh        = advance_cell(s.head, c.dir);
      n.head    = nh;
      n.body[0] = nh;
      for (i = 1; i < MAX_LENGTH; i++) begin
        n.body[i] = s.body[i-1];
      end
      if (c.apple) begin
        if (int'(s.score) < MAX_LENGTH - 2) begin
          n.score = s.score + 1'b1;
        end
      end else begin
        // length rule uses the score from before the edge
        for (i = 0; i < MAX_LENGTH; i++) begin
          if (i >= int'(s.score) + 2) begin
            n.body[i] = '0;
          end
        end
      end
    end
    return n;
  endfunction

  task automatic check_value(input string field, input logic [WIDE-1:0] exp,
                             input logic [WIDE-1:0] act);
    checks++;
    test_checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("ERR %s %s expected %h actual %h", test_name(cur_id), field, exp, act);
    end
  endtask

  initial begin
    ticks_seen  = 0;
    checks      = 0;
    errors      = 0;
    cur_id      = 0;
    test_checks = 0;
    test_errors = 0;
    model       = start_state();
  end

  // inputs are stable at the rising edge, outputs settle just after it
  always @(posedge main_clk) begin
    sampled.run    = run;
    sampled.tick   = body_tick;
    sampled.enable = enable;
    sampled.apple  = apple_hit;
    sampled.wall   = wall_hit;
    sampled.dir    = dir;
    if (!nrst) begin
      model = start_state();
    end else begin
      model = predict_next(model, sampled);
      if (body_tick) begin
        ticks_seen++;
      end
    end
    #1;
    check_value("head", WIDE'(model.head), WIDE'(head));
    check_value("body", WIDE'(model.body), WIDE'(body));
    check_value("score", WIDE'(model.score), WIDE'(score));
  end

  // result line for a test once the next one starts
  always @(test_id) begin
    if (test_id != cur_id) begin
      $display("test %s: %0d checks, %0d errors, %s", test_name(cur_id),
               test_checks, test_errors, (test_errors == 0) ? "pass" : "FAIL");
      cur_id      = test_id;
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule

`default_nettype wire

//--- src/snake_body_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module snake_body_ctrl #(
  parameter int MAX_LENGTH = 30
) (
  input  logic                                  main_clk,
  input  logic                                  nrst,
  // level, low pauses the game
  input  logic                                  run,
  // one main_clk wide strobe per body step
  input  logic                                  body_tick,
  input  logic                                  enable,
  input  logic                                  apple_hit,
  input  logic                                  wall_hit,
  input  snake_geom_pkg::dir_e                  dir,
  output snake_geom_pkg::pos_t                  head,
  output snake_geom_pkg::pos_t [MAX_LENGTH-1:0] body,
  output logic [snake_geom_pkg::SCORE_W-1:0]    score
);

  import snake_ctrl_pkg::*;

  // decoded action, shared by both position keepers
  step_cmd_t cmd;

  // strobes and collisions in, command and score out
  move_sequencer #(
    .MAX_LENGTH (MAX_LENGTH)
  ) move_sequencer_i (
    .main_clk  (main_clk),
    .nrst      (nrst),
    .run       (run),
    .body_tick (body_tick),
    .enable    (enable),
    .apple_hit (apple_hit),
    .wall_hit  (wall_hit),
    .dir       (dir),
    .cmd       (cmd),
    .score     (score)
  );

  // head cell
  head_stepper head_stepper_i (
    .main_clk (main_clk),
    .nrst     (nrst),
    .cmd      (cmd),
    .head     (head)
  );

  // segment list, length follows the score
  body_shifter #(
    .MAX_LENGTH (MAX_LENGTH)
  ) body_shifter_i (
    .main_clk (main_clk),
    .nrst     (nrst),
    .cmd      (cmd),
    .score    (score),
    .body     (body)
  );

endmodule

`default_nettype wire

//--- src/body_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module body_shifter #(
  parameter int MAX_LENGTH = 30
) (
  input  logic                                 main_clk,
  input  logic                                 nrst,
  input  snake_ctrl_pkg::step_cmd_t            cmd,
  input  logic [snake_geom_pkg::SCORE_W-1:0]   score,
  output snake_geom_pkg::pos_t [MAX_LENGTH-1:0] body
);

  import snake_geom_pkg::*;
  import snake_ctrl_pkg::*;

  // stepped head for this tick
  pos_t                  next_head;
  // body with the new head pushed in at index 0
  pos_t [MAX_LENGTH-1:0] shifted;
  // shifted body cut back to score+2 segments
  pos_t [MAX_LENGTH-1:0] trimmed;
  // head and one tail segment with everything else empty
  pos_t [MAX_LENGTH-1:0] start_body;

  // index 0 mirrors the head register so step from it directly
  // the head module updates on the same edge and its output is still the old value
  assign next_head = step_pos(body[0], cmd.dir);

  // oldest segment drops off the far end
  assign shifted = {body[MAX_LENGTH-2:0], next_head};

  // a plain move keeps score+2 cells and clears the rest
  always_comb begin
    trimmed = shifted;
    for (int i = 0; i < MAX_LENGTH; i++) begin
      if (i >= int'(score) + 2) begin
        trimmed[i] = '0;
      end
    end
  end

  always_comb begin
    start_body    = '0;
    start_body[0] = START_HEAD;
    start_body[1] = START_TAIL;
  end

  // segment list register
  always_ff @(posedge main_clk or negedge nrst) begin
    if (!nrst) begin
      body <= start_body;
    end else begin
      case (cmd.act)
        act_move: begin
          body <= trimmed;
        end
        act_grow: begin
          // tail stays so the snake is one cell longer
          body <= shifted;
        end
        act_restart: begin
          body <= start_body;
        end
        default: begin
          body <= body;
        end
      endcase
    end
  end

  // index 0 tracks the head and lands on START_HEAD after a restart
  // or on the cell one step from the old head otherwise
  a_body_head_entry : assert property (
    @(posedge main_clk) disable iff (!nrst)
    (cmd.act != act_hold) |=>
      body[0] == (($past(cmd.act) == act_restart) ? START_HEAD : $past(next_head))
  ) else $error("body index 0 does not follow the head");

endmodule

`default_nettype wire

//--- src/head_stepper.sv
`timescale 1ns/10ps
`default_nettype none

module head_stepper (
  input  logic                      main_clk,
  input  logic                      nrst,
  input  snake_ctrl_pkg::step_cmd_t cmd,
  output snake_geom_pkg::pos_t      head
);

  import snake_geom_pkg::*;
  import snake_ctrl_pkg::*;

  // head register
  // move and grow both advance one cell, restart reloads the start cell
  always_ff @(posedge main_clk or negedge nrst) begin
    if (!nrst) begin
      head <= START_HEAD;
    end else begin
      case (cmd.act)
        act_move, act_grow: begin
          head <= step_pos(head, cmd.dir);
        end
        act_restart: begin
          head <= START_HEAD;
        end
        default: begin
          // hold
          head <= head;
        end
      endcase
    end
  end

  // true when a and b are neighbours on the wrapped grid
  function automatic logic one_cell_apart(pos_t a, pos_t b);
    coord_t dx;
    coord_t dy;
    logic   x_step;
    logic   y_step;
    dx = a.x - b.x;
    dy = a.y - b.y;
    // distance of one either way, 15 is -1 modulo 16
    x_step = (dx == coord_t'(1)) || (dx == coord_t'(15));
    y_step = (dy == coord_t'(1)) || (dy == coord_t'(15));
    return (x_step && dy == '0) || (y_step && dx == '0);
  endfunction

  // a move never jumps, only one axis changes by one cell
  a_head_one_cell : assert property (
    @(posedge main_clk) disable iff (!nrst)
    (cmd.act inside {act_move, act_grow}) |=> one_cell_apart($past(head), head)
  ) else $error("head moved by more than one cell");

endmodule

`default_nettype wire

//--- src/move_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module move_sequencer #(
  parameter int MAX_LENGTH = 30
) (
  input  logic                              main_clk,
  input  logic                              nrst,
  input  logic                              run,
  input  logic                              body_tick,
  input  logic                              enable,
  input  logic                              apple_hit,
  input  logic                              wall_hit,
  input  snake_geom_pkg::dir_e              dir,
  output snake_ctrl_pkg::step_cmd_t         cmd,
  output logic [snake_geom_pkg::SCORE_W-1:0] score
);

  import snake_geom_pkg::*;
  import snake_ctrl_pkg::*;

  // body holds at most MAX_LENGTH cells and the score counts the ones past two
  localparam logic [SCORE_W-1:0] SCORE_MAX = SCORE_W'(MAX_LENGTH - 2);

  // action decode is the only place the strobes and collisions are looked at
  always_comb begin
    cmd.dir = dir;
    if (!(run && body_tick)) begin
      // paused or between ticks
      cmd.act = act_hold;
    end else if (wall_hit) begin
      // wall restarts even with enable low
      cmd.act = act_restart;
    end else if (!enable) begin
      cmd.act = act_hold;
    end else if (apple_hit) begin
      cmd.act = act_grow;
    end else begin
      cmd.act = act_move;
    end
  end

  // score counter that saturates once the body fills the array
  always_ff @(posedge main_clk or negedge nrst) begin
    if (!nrst) begin
      score <= '0;
    end else if (cmd.act == act_grow && score < SCORE_MAX) begin
      score <= score + 1'b1;
    end
  end

  // collision detector must never flag apple and wall in one cycle
  a_single_hit : assert property (
    @(posedge main_clk) disable iff (!nrst)
    run |-> !(apple_hit && wall_hit)
  ) else $error("apple_hit and wall_hit high together");

endmodule

`default_nettype wire

//--- src/snake_ctrl_pkg.sv
`default_nettype none

package snake_ctrl_pkg;

  // what the position registers do on the coming edge
  // hold   nothing changes
  // move   head steps, body shifts and is trimmed to score+2
  // grow   head steps, body shifts and keeps its tail
  // restart back to the start pose
  typedef enum logic [1:0] {
    act_hold    = 2'd0,
    act_move    = 2'd1,
    act_grow    = 2'd2,
    act_restart = 2'd3
  } act_e;

  // command from the sequencer to both position keepers
  // dir is passed along on every cycle, only used on move and grow
  typedef struct packed {
    act_e                 act;
    snake_geom_pkg::dir_e dir;
  } step_cmd_t;

endpackage

`default_nettype wire

//--- src/snake_geom_pkg.sv
`default_nettype none

package snake_geom_pkg;

  // one grid axis, the 16x16 board wraps at both edges
  localparam int COORD_W = 4;
  // score counter width
  localparam int SCORE_W = 8;

  typedef logic [COORD_W-1:0] coord_t;

  // a single grid cell
  typedef struct packed {
    coord_t x;
    coord_t y;
  } pos_t;

  // up and left decrement, down and right increment
  typedef enum logic [1:0] {
    dir_up    = 2'd0,
    dir_down  = 2'd1,
    dir_right = 2'd2,
    dir_left  = 2'd3
  } dir_e;

  // start pose, head with one segment trailing to the left
  localparam pos_t START_HEAD = '{x: 4'd4, y: 4'd4};
  localparam pos_t START_TAIL = '{x: 4'd3, y: 4'd4};

  // one cell step in the given direction, wraps modulo 16
  function automatic pos_t step_pos(pos_t p, dir_e d);
    pos_t q;
    q = p;
    case (d)
      dir_up:    q.y = p.y - coord_t'(1);
      dir_down:  q.y = p.y + coord_t'(1);
      dir_right: q.x = p.x + coord_t'(1);
      dir_left:  q.x = p.x - coord_t'(1);
      default:   q = p;
    endcase
    return q;
  endfunction

endpackage

`default_nettype wire
